// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_drum_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= TEST PASS
FAIL_MSG  ?= TEST FAIL

SOURCES := $(wildcard logic/*.sv verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+verification
logic/drum_pkg.sv
logic/column_ram.sv
logic/node_update.sv
logic/tension_control.sv
logic/column_solver.sv
logic/drum_top.sv
verification/tb_drum_top.sv

// ==== logic/column_ram.sv ====
// column_ram: one column of node values, synchronous write, registered read
`timescale 1ns/1ps

module column_ram (
    input  logic                        clk,
    input  logic                        write_en,
    input  logic [drum_pkg::ADDR_W-1:0] write_addr,
    input  logic [drum_pkg::ADDR_W-1:0] read_addr,
    input  logic [drum_pkg::DATA_W-1:0] write_data,
    output logic [drum_pkg::DATA_W-1:0] read_data
);

    import drum_pkg::*;

    // one word per grid row
    logic [DATA_W-1:0] mem [GRID_N];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        // same-address write is seen one cycle later
        read_data <= mem[read_addr];
    end

endmodule

// ==== logic/column_solver.sv ====
// column_solver: pyramid load, row sweep FSM, current and previous row memories
`timescale 1ns/1ps

module column_solver #(
    parameter int col_index = 0
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               audio_request,
    input  logic        [drum_pkg::DATA_W-1:0] rho,
    input  logic signed [drum_pkg::DATA_W-1:0] u_left,
    input  logic signed [drum_pkg::DATA_W-1:0] u_right,
    output logic signed [drum_pkg::DATA_W-1:0] row_value,
    output logic signed [drum_pkg::DATA_W-1:0] center_value,
    output logic                               ready
);

    import drum_pkg::*;

    // ====================================================================
    // declarations
    // ====================================================================
    logic [STATE_W-1:0] state;
    logic [ADDR_W-1:0]  row;
    logic               last_row;

    // node at the sweep row and the one below, both at step n
    logic signed [DATA_W-1:0] u_curr;
    logic signed [DATA_W-1:0] u_bottom;
    logic signed [DATA_W-1:0] center_hold;

    // memory read side
    logic [ADDR_W-1:0]        curr_rd_addr;
    logic signed [DATA_W-1:0] curr_rd;
    logic signed [DATA_W-1:0] prev_rd;

    // memory write side, both memories share address and enable
    logic                     ram_we;
    logic signed [DATA_W-1:0] curr_wr_data;
    logic signed [DATA_W-1:0] prev_wr_data;

    // node arithmetic inputs after boundary masking
    logic signed [DATA_W-1:0] u_top;
    logic signed [DATA_W-1:0] u_left_eff;
    logic signed [DATA_W-1:0] u_right_eff;
    logic signed [DATA_W-1:0] u_next;

    // pyramid generator
    logic [ADDR_W-1:0]        row_ring;
    logic [ADDR_W-1:0]        col_ring;
    logic [ADDR_W-1:0]        ring;
    logic signed [DATA_W-1:0] init_value;

    // ====================================================================
    // initial shape
    // ====================================================================
    // height = INIT_STEP * distance to the nearest edge
    assign row_ring = (row < LAST_ROW - row) ? row : LAST_ROW - row;
    assign col_ring = (col_index < GRID_N - 1 - col_index) ?
                      ADDR_W'(col_index) : ADDR_W'(GRID_N - 1 - col_index);
    assign ring = (row_ring < col_ring) ? row_ring : col_ring;
    assign init_value = $signed(DATA_W'(ring)) * INIT_STEP;

    // ====================================================================
    // row memories
    // ====================================================================
    assign last_row = (row == LAST_ROW);
    assign ram_we = (state == ST_LOAD) || (state == ST_CALC);

    // load writes the same shape to both, so the drum starts at rest
    assign curr_wr_data = (state == ST_LOAD) ? init_value : u_next;
    assign prev_wr_data = (state == ST_LOAD) ? init_value : u_curr;

    // fetch the row above
    // otherwise park on row 0, ready for the next sweep
    assign curr_rd_addr = (state == ST_READ && !last_row) ? row + 1'b1 : '0;

    // step n, new values overwrite rows already passed
    column_ram curr_ram (
        .clk        (clk),
        .write_en   (ram_we),
        .write_addr (row),
        .read_addr  (curr_rd_addr),
        .write_data (curr_wr_data),
        .read_data  (curr_rd)
    );

    // step n-1
    column_ram prev_ram (
        .clk        (clk),
        .write_en   (ram_we),
        .write_addr (row),
        .read_addr  (row),
        .write_data (prev_wr_data),
        .read_data  (prev_rd)
    );

    // ====================================================================
    // node arithmetic
    // ====================================================================
    // clamped edges of the membrane
    assign u_top       = last_row ? '0 : curr_rd;
    assign u_left_eff  = (col_index == 0) ? '0 : u_left;
    assign u_right_eff = (col_index == GRID_N - 1) ? '0 : u_right;

    node_update node (
        .rho      (rho),
        .u_top    (u_top),
        .u_bottom (u_bottom),
        .u_left   (u_left_eff),
        .u_right  (u_right_eff),
        .u_prev   (prev_rd),
        .u_curr   (u_curr),
        .u_next   (u_next)
    );

    // ====================================================================
    // sweep FSM
    // ====================================================================
    // every column runs the same sequence, so all stay on one row
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_LOAD;
            row   <= '0;
        end else begin
            // one row per write, wrap after the top
            if (ram_we) begin
                row <= last_row ? '0 : row + 1'b1;
            end

            case (state)
                ST_LOAD: begin
                    if (last_row) begin
                        state <= ST_DONE;
                    end
                end
                ST_READ: begin
                    state <= ST_CALC;
                end
                ST_CALC: begin
                    state <= last_row ? ST_DONE : ST_READ;
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                ST_IDLE: begin
                    // requests outside idle are simply lost
                    if (audio_request) begin
                        state <= ST_READ;
                    end
                end
                default: begin
                    state <= ST_LOAD;
                end
            endcase
        end
    end

    // ====================================================================
    // row registers and centre output
    // ====================================================================
    always_ff @(posedge clk) begin
        // shift up one row, the read port has the row above
        if (state == ST_CALC) begin
            u_bottom <= u_curr;
            u_curr   <= curr_rd;
        end
        // prime with row 0 and a zero bottom for the next sweep
        if (state == ST_DONE) begin
            u_bottom <= '0;
            u_curr   <= curr_rd;
        end
        if (ram_we && row == CENTER_IDX) begin
            center_hold <= curr_wr_data;
        end
        // publish when the top row is written
        if (ram_we && last_row) begin
            center_value <= center_hold;
        end
    end

    assign row_value = u_curr;
    assign ready     = (state == ST_IDLE);

endmodule

// ==== logic/drum_pkg.sv ====
// drum_pkg: grid size, 1.17 fixed-point constants, sweep state codes, fixed_mul
package drum_pkg;

    // ====================================================================
    // grid geometry
    // ====================================================================
    localparam int GRID_N     = 30;
    localparam int CENTER_IDX = 15;
    localparam int ADDR_W     = 5;

    // top row of a column, boundary side
    localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(GRID_N - 1);

    // ====================================================================
    // 1.17 fixed point
    // ====================================================================
    localparam int DATA_W = 18;
    localparam int FRAC_W = 17;

    // pyramid ring height, 2^-9
    localparam logic signed [DATA_W-1:0] INIT_STEP = DATA_W'(1 << (FRAC_W - 9));
    // base tension 0.25
    localparam logic signed [DATA_W-1:0] RHO_0 = DATA_W'(1 << (FRAC_W - 2));
    // ceiling 0.5 - 2^-7
    localparam logic signed [DATA_W-1:0] RHO_MAX =
        DATA_W'((1 << (FRAC_W - 1)) - (1 << (FRAC_W - 7)));

    localparam int TENSION_SHIFT = 4;
    localparam int DAMP_SHIFT    = 10;

    // ====================================================================
    // column sweep FSM
    // ====================================================================
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_LOAD = STATE_W'(0);
    localparam logic [STATE_W-1:0] ST_READ = STATE_W'(1);
    localparam logic [STATE_W-1:0] ST_CALC = STATE_W'(2);
    localparam logic [STATE_W-1:0] ST_DONE = STATE_W'(3);
    localparam logic [STATE_W-1:0] ST_IDLE = STATE_W'(4);

    // 1.17 times 1.17, keep sign plus bits 33..17 of the 2.34 product
    function automatic logic signed [DATA_W-1:0] fixed_mul(
        input logic signed [DATA_W-1:0] a,
        input logic signed [DATA_W-1:0] b
    );
        logic signed [2*DATA_W-1:0] product;
        product = a * b;
        return {product[2*DATA_W-1], product[2*DATA_W-3:FRAC_W]};
    endfunction

endpackage

// ==== logic/drum_top.sv ====
// drum_top: column solver array, neighbour wiring, tension control
`timescale 1ns/1ps

module drum_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               audio_request,
    output logic                               ready,
    output logic signed [drum_pkg::DATA_W-1:0] center_sample
);

    import drum_pkg::*;

    // shared tension, constant over one sweep
    logic        [DATA_W-1:0] rho;
    // each column's node at the sweep row
    logic signed [DATA_W-1:0] row_value [GRID_N];

    // ====================================================================
    // nonlinear tension
    // ====================================================================
    tension_control tension (
        .clk           (clk),
        .reset         (reset),
        .ready         (ready),
        .center_sample (center_sample),
        .rho           (rho)
    );

    // ====================================================================
    // solver array
    // ====================================================================
    // neighbour indices wrap around here
    // the edge columns zero them inside the solver
    for (genvar i = 0; i < GRID_N; i++) begin : g_column
        if (i == CENTER_IDX) begin : g_center
            // only this column reports the centre node and step status
            column_solver #(
                .col_index (i)
            ) solver (
                .clk           (clk),
                .reset         (reset),
                .audio_request (audio_request),
                .rho           (rho),
                .u_left        (row_value[(i + GRID_N - 1) % GRID_N]),
                .u_right       (row_value[(i + 1) % GRID_N]),
                .row_value     (row_value[i]),
                .center_value  (center_sample),
                .ready         (ready)
            );
        end else begin : g_plain
            column_solver #(
                .col_index (i)
            ) solver (
                .clk           (clk),
                .reset         (reset),
                .audio_request (audio_request),
                .rho           (rho),
                .u_left        (row_value[(i + GRID_N - 1) % GRID_N]),
                .u_right       (row_value[(i + 1) % GRID_N]),
                .row_value     (row_value[i]),
                .center_value  (),
                .ready         ()
            );
        end
    end

endmodule

// ==== logic/node_update.sv ====
// node_update: damped finite-difference step of one membrane node
`timescale 1ns/1ps

module node_update (
    input  logic signed [drum_pkg::DATA_W-1:0] rho,
    input  logic signed [drum_pkg::DATA_W-1:0] u_top,
    input  logic signed [drum_pkg::DATA_W-1:0] u_bottom,
    input  logic signed [drum_pkg::DATA_W-1:0] u_left,
    input  logic signed [drum_pkg::DATA_W-1:0] u_right,
    input  logic signed [drum_pkg::DATA_W-1:0] u_prev,
    input  logic signed [drum_pkg::DATA_W-1:0] u_curr,
    output logic signed [drum_pkg::DATA_W-1:0] u_next
);

    import drum_pkg::*;

    // discrete laplacian, wraps at 18 bits
    logic signed [DATA_W-1:0] diff_sum;
    // rho times laplacian
    logic signed [DATA_W-1:0] coupling;
    // leapfrog result before the output damping
    logic signed [DATA_W-1:0] mid_term;

    assign diff_sum = (u_left - u_curr) + (u_right - u_curr)
                    + (u_bottom - u_curr) + (u_top - u_curr);

    assign coupling = fixed_mul(rho, diff_sum);

    // 2*u(n) - u(n-1), with a little of u(n-1) handed back
    assign mid_term = coupling + (u_curr <<< 1) - u_prev + (u_prev >>> DAMP_SHIFT);

    // bleed off 2^-10 of the new height
    assign u_next = mid_term - (mid_term >>> DAMP_SHIFT);

endmodule

// ==== logic/tension_control.sv ====
// tension_control: effective membrane tension from the centre displacement
`timescale 1ns/1ps

module tension_control (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ready,
    input  logic signed [drum_pkg::DATA_W-1:0] center_sample,
    output logic        [drum_pkg::DATA_W-1:0] rho
);

    import drum_pkg::*;

    logic signed [DATA_W-1:0] center_scaled;
    logic signed [DATA_W-1:0] tension_gain;
    logic signed [DATA_W-1:0] rho_sum;
    logic        [DATA_W-1:0] rho_next;

    // pre-scale so the square stays small
    assign center_scaled = center_sample >>> TENSION_SHIFT;

    // square term, never negative
    assign tension_gain = fixed_mul(center_scaled, center_scaled);

    assign rho_sum = RHO_0 + tension_gain;

    // smaller of the two, stiffer drum up to the ceiling
    assign rho_next = (rho_sum < RHO_MAX) ? rho_sum : RHO_MAX;

    // follow the centre only between steps
    // whole sweep then sees one tension value
    always_ff @(posedge clk) begin
        if (reset) begin
            rho <= RHO_0;
        end else if (ready) begin
            rho <= rho_next;
        end
    end

endmodule

// ==== verification/drum_model.svh ====
// reference membrane model: pyramid start, one damped time step, nonlinear tension
`ifndef DRUM_MODEL_SVH
`define DRUM_MODEL_SVH

// tension constants straight from the 1.17 values 0.25 and 63/128
localparam logic signed [DATA_W-1:0] MODEL_RHO_BASE = DATA_W'(1 << (FRAC_W - 2));
localparam logic signed [DATA_W-1:0] MODEL_RHO_CEIL = DATA_W'(63 << (FRAC_W - 7));

// heights at step n and n-1, indexed [row][column]
logic signed [DATA_W-1:0] model_curr [GRID_N][GRID_N];
logic signed [DATA_W-1:0] model_prev [GRID_N][GRID_N];

// sign bit, then product bits 33 down to 17
function automatic logic signed [DATA_W-1:0] model_mul(
    input logic signed [DATA_W-1:0] a,
    input logic signed [DATA_W-1:0] b
);
    logic signed [2*DATA_W-1:0] wide_a;
    logic signed [2*DATA_W-1:0] wide_b;
    logic signed [2*DATA_W-1:0] full;
    wide_a = a;
    wide_b = b;
    full = wide_a * wide_b;
    return {full[2*DATA_W-1], full[2*DATA_W-3:FRAC_W]};
endfunction

// centre scaled down, squared, added to the base, capped
function automatic logic signed [DATA_W-1:0] model_rho(input logic signed [DATA_W-1:0] center);
    logic signed [DATA_W-1:0] scaled;
    logic signed [DATA_W-1:0] sum;
    scaled = center >>> TENSION_SHIFT;
    sum = MODEL_RHO_BASE + model_mul(scaled, scaled);
    return (sum < MODEL_RHO_CEIL) ? sum : MODEL_RHO_CEIL;
endfunction

// pyramid, 2^-9 per ring from the edge
task automatic model_load_pyramid();
    int ring;
    for (int r = 0; r < GRID_N; r++) begin
        for (int c = 0; c < GRID_N; c++) begin
            ring = (r < c) ? r : c;
            ring = (GRID_N - 1 - r < ring) ? GRID_N - 1 - r : ring;
            ring = (GRID_N - 1 - c < ring) ? GRID_N - 1 - c : ring;
            model_curr[r][c] = DATA_W'(ring << (FRAC_W - 9));
            model_prev[r][c] = DATA_W'(ring << (FRAC_W - 9));
        end
    end
endtask

// whole grid, old values only, zero outside the membrane
task automatic model_step();
    logic signed [DATA_W-1:0] next_grid [GRID_N][GRID_N];
    logic signed [DATA_W-1:0] rho;
    logic signed [DATA_W-1:0] up;
    logic signed [DATA_W-1:0] down;
    logic signed [DATA_W-1:0] west;
    logic signed [DATA_W-1:0] east;
    logic signed [DATA_W-1:0] diff;
    logic signed [DATA_W-1:0] m;
    logic signed [DATA_W-1:0] prev;
    logic signed [DATA_W-1:0] curr;
    // tension from the newest published centre
    rho = model_rho(model_curr[CENTER_IDX][CENTER_IDX]);
    for (int r = 0; r < GRID_N; r++) begin
        for (int c = 0; c < GRID_N; c++) begin
            curr = model_curr[r][c];
            prev = model_prev[r][c];
            down = (r == 0) ? '0 : model_curr[r-1][c];
            up   = (r == GRID_N - 1) ? '0 : model_curr[r+1][c];
            west = (c == 0) ? '0 : model_curr[r][c-1];
            east = (c == GRID_N - 1) ? '0 : model_curr[r][c+1];
            diff = (west - curr) + (east - curr) + (down - curr) + (up - curr);
            m = model_mul(rho, diff) + (curr <<< 1) - prev + (prev >>> DAMP_SHIFT);
            next_grid[r][c] = m - (m >>> DAMP_SHIFT);
        end
    end
    model_prev = model_curr;
    model_curr = next_grid;
endtask

`endif

// ==== verification/tb_drum_top.sv ====
// testbench for the drum synthesizer top level: clock, reset, requests, checks, report
`timescale 1ns/1ps

module tb_drum_top;

    import drum_pkg::*;

    localparam int READY_TIMEOUT = 1000;
    localparam int STEP_COUNT    = 20;

    logic                     clk;
    logic                     reset;
    logic                     audio_request;
    logic                     ready;
    logic signed [DATA_W-1:0] center_sample;

    int error_count;
    int tests_passed;
    int tests_failed;
    int steps_done;

    drum_top DUT (
        .clk           (clk),
        .reset         (reset),
        .audio_request (audio_request),
        .ready         (ready),
        .center_sample (center_sample)
    );

    `include "drum_model.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // protocol properties
    // ======================================================================
    // low through reset and one cycle beyond
    assert property (@(posedge clk) reset |=> !ready)
        else begin
            $display("ERROR %0t ns: ready high during or right after reset", $time);
            error_count++;
        end
    // accepted request, sweep starts next cycle
    assert property (@(posedge clk) disable iff (reset) (ready && audio_request) |=> !ready)
        else begin
            $display("ERROR %0t ns: ready still high after an accepted request", $time);
            error_count++;
        end
    // idle and quiet, nothing moves
    assert property (@(posedge clk) disable iff (reset)
        (ready && !audio_request) |=> (ready && $stable(center_sample)))
        else begin
            $display("ERROR %0t ns: grid left idle or centre moved without a request", $time);
            error_count++;
        end

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic wait_for_ready(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (ready !== 1'b1 && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ready !== 1'b1) begin
            $display("timeout: ready never rose %s within %0d cycles", what, READY_TIMEOUT);
            $display("TEST FAIL");
            $finish;
        end
    endtask

    // one-cycle pulse from idle, ready drops right after
    task automatic send_request();
        @(posedge clk);
        audio_request <= 1'b1;
        @(posedge clk);
        audio_request <= 1'b0;
        @(negedge clk);
        assert (ready === 1'b0) else begin
            $display("ERROR %0t ns: ready did not fall after a request", $time);
            error_count++;
        end
    endtask

    // pulse sampled by the DUT while a sweep is still running
    task automatic pulse_busy_request();
        @(posedge clk);
        audio_request <= 1'b1;
        @(negedge clk);
        assert (ready === 1'b0) else begin
            $display("busy request was sent while the grid was already idle");
            error_count++;
        end
        @(posedge clk);
        audio_request <= 1'b0;
    endtask

    task automatic compare_center(input logic signed [DATA_W-1:0] expected, input string label);
        assert (center_sample === expected) else begin
            $display("ERROR %0t ns: center_sample %0d, expected %0d (%s)",
                     $time, center_sample, expected, label);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("[%s] passed", name);
        end else begin
            tests_failed++;
            $display("[%s] failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int errors_before;
        int gap;
        logic signed [DATA_W-1:0] held;
        reset = 1'b1;
        audio_request = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        steps_done = 0;
        void'($urandom(32'he29e));

        // reset, then the initial load runs to ready
        errors_before = error_count;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait_for_ready("after reset");
        report_test("reset and load", errors_before);

        // pyramid peak, ring 14 at the centre
        errors_before = error_count;
        model_load_pyramid();
        compare_center(model_curr[CENTER_IDX][CENTER_IDX], "initial pyramid");
        report_test("initial shape", errors_before);

        errors_before = error_count;
        gap = 8 + ($urandom % 32);
        held = center_sample;
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            assert (ready === 1'b1 && center_sample === held) else begin
                $display("ERROR %0t ns: idle grid changed, ready %b centre %0d",
                         $time, ready, center_sample);
                error_count++;
            end
        end
        report_test("idle hold", errors_before);

        // steps with random idle gaps, tension follows the centre
        errors_before = error_count;
        for (int k = 0; k < STEP_COUNT; k++) begin
            repeat ($urandom % 6) @(posedge clk);
            send_request();
            wait_for_ready("after a step");
            model_step();
            steps_done++;
            compare_center(model_curr[CENTER_IDX][CENTER_IDX], $sformatf("step %0d", steps_done));
        end
        report_test("step results", errors_before);

        // extra pulses mid-sweep are dropped
        errors_before = error_count;
        repeat (3) begin
            send_request();
            repeat (2 + ($urandom % 10)) @(posedge clk);
            pulse_busy_request();
            repeat (2 + ($urandom % 10)) @(posedge clk);
            pulse_busy_request();
            wait_for_ready("after busy requests");
            model_step();
            steps_done++;
            compare_center(model_curr[CENTER_IDX][CENTER_IDX], $sformatf("step %0d", steps_done));
        end
        report_test("busy requests", errors_before);

        $display("tests passed %0d, failed %0d, errors %0d, steps %0d",
                 tests_passed, tests_failed, error_count, steps_done);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
